// ==== flist.f ====
source/wrap_cfg_pkg.sv
source/bus_pkg.sv
source/cdc_fifo_src.sv
source/port_channel.sv
source/port_decoder.sv
source/resp_collector.sv
source/ext_port_wrap.sv
sim/tb_ext_port_wrap.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, and decide the result from the log

rm -rf obj_dir sim.log

verilator --binary --timing -f flist.f \
  --top-module tb_ext_port_wrap -o tb_ext_port_wrap \
  && ./obj_dir/tb_ext_port_wrap | tee sim.log \
  && grep -q "Simulation PASSED" sim.log \
  && echo "run.sh: test passed" \
  || { echo "run.sh: test failed"; exit 1; }

// ==== sim/tb_ext_port_wrap.sv ====
module tb_ext_port_wrap;

  localparam int NumPorts   = wrap_cfg_pkg::DefaultNumPorts;
  localparam int LogDepth   = wrap_cfg_pkg::DefaultLogDepth;
  localparam int SyncStages = wrap_cfg_pkg::DefaultSyncStages;
  localparam int Depth      = 2**LogDepth;
  localparam int PtrWidth   = LogDepth + 1;
  localparam int NumCodes   = 2**wrap_cfg_pkg::PortSelWidth;
  localparam int ClkPeriod  = 8;
  localparam int Quarter    = ClkPeriod / 4;
  localparam int ResetCycles = 16;
  localparam int AcceptTimeout = 100;
  localparam int RespTimeout   = 200;
  localparam int BpPort  = 1;
  localparam int IsoPort = 2;

  // Cycle budget of each test, reset first
  localparam int TestCycles = ResetCycles + 30 + 250 + 100 + 200 + 250 + 150;
  localparam int WatchdogTime = TestCycles * 4 * ClkPeriod;

  logic                                               clk_i = 1'b0;
  logic                                               reset_i;
  logic                                               req_valid_i;
  bus_pkg::wr_req_t                                   req_i;
  logic                                               req_ready_o;
  logic                                               resp_valid_o;
  bus_pkg::wr_resp_t                                  resp_o;
  logic [NumPorts-1:0]                                isolate_i;
  logic [NumPorts-1:0]                                isolated_o;
  bus_pkg::wr_req_t [NumPorts-1:0][Depth-1:0]         async_data_o;
  logic [NumPorts-1:0][LogDepth:0]                    async_wptr_o;
  logic [NumPorts-1:0][LogDepth:0]                    async_rptr_i = '0;

  // Far-side model state
  logic [NumPorts-1:0] pop_en;
  logic [LogDepth:0]   rptr_bin [NumPorts] = '{default: '0};
  bus_pkg::wr_req_t    exp_mem [NumPorts][64];
  int                  exp_wr [NumPorts] = '{default: 0};
  int                  exp_rd [NumPorts] = '{default: 0};

  // Response counts by tagged port and status
  int    resp_cnt [NumCodes][4] = '{default: 0};
  int    base_cnt [NumCodes][4];
  int    resp_total = 0;
  int    base_total;
  string cur_test = "none";

  ext_port_wrap #(
    .NumPorts   ( NumPorts   ),
    .LogDepth   ( LogDepth   ),
    .SyncStages ( SyncStages )
  ) UUT (
    .clk_i        ( clk_i        ),
    .reset_i      ( reset_i      ),
    .req_valid_i  ( req_valid_i  ),
    .req_i        ( req_i        ),
    .req_ready_o  ( req_ready_o  ),
    .resp_valid_o ( resp_valid_o ),
    .resp_o       ( resp_o       ),
    .isolate_i    ( isolate_i    ),
    .isolated_o   ( isolated_o   ),
    .async_data_o ( async_data_o ),
    .async_wptr_o ( async_wptr_o ),
    .async_rptr_i ( async_rptr_i )
  );

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string what, input logic [63:0] exp_val,
                             input logic [63:0] act_val);
    if (act_val !== exp_val) begin
      stop_on_error($sformatf("ERR %s: %s expected %0h actual %0h",
                              cur_test, what, exp_val, act_val));
    end
  endtask

  function automatic logic [LogDepth:0] to_gray(input logic [LogDepth:0] bin);
    return bin ^ (bin >> 1);
  endfunction

  // Far side reads the entry at its pointer and compares it in order
  task automatic pop_entry(input int p);
    bus_pkg::wr_req_t got;
    got = async_data_o[p][rptr_bin[p][LogDepth-1:0]];
    if (exp_rd[p] == exp_wr[p]) begin
      stop_on_error($sformatf("Port %0d far side found an entry that no write put there", p));
    end
    check_value($sformatf("port %0d entry %0d", p, exp_rd[p]), exp_mem[p][exp_rd[p]], got);
    exp_rd[p] = exp_rd[p] + 1;
    rptr_bin[p] = rptr_bin[p] + PtrWidth'(1);
    async_rptr_i[p] = to_gray(rptr_bin[p]);
  endtask

  // Random read delay of zero to a few cycles
  always @(negedge clk_i) begin
    if (!reset_i) begin
      for (int p = 0; p < NumPorts; p++) begin
        if (pop_en[p] && (async_wptr_o[p] != async_rptr_i[p]) && ($urandom_range(3) != 0)) begin
          pop_entry(p);
        end
      end
    end
  end

  always @(negedge clk_i) begin
    if (!reset_i && resp_valid_o) begin
      resp_cnt[resp_o.port][resp_o.status] = resp_cnt[resp_o.port][resp_o.status] + 1;
      resp_total = resp_total + 1;
    end
  end

  initial begin
    #(WatchdogTime);
    stop_on_error($sformatf("Timeout: run did not finish within %0d time units", WatchdogTime));
  end

  function automatic int count_since(input int code, input int status);
    return resp_cnt[code][status] - base_cnt[code][status];
  endfunction

  function automatic bus_pkg::wr_req_t make_req(input int code);
    bus_pkg::wr_req_t req;
    req.addr = $urandom;
    req.data = $urandom;
    req.addr[wrap_cfg_pkg::PortSelLsb +: wrap_cfg_pkg::PortSelWidth] = bus_pkg::port_id_t'(code);
    return req;
  endfunction

  // Ends a quarter period after a falling edge, where outputs are settled
  task automatic settle(input int n);
    repeat (n) @(negedge clk_i);
    #(Quarter);
  endtask

  task automatic snap_counts();
    settle(1);
    base_cnt   = resp_cnt;
    base_total = resp_total;
  endtask

  task automatic drive_req(input bus_pkg::wr_req_t req, input int code, input bit to_far);
    @(negedge clk_i);
    if (to_far) begin
      exp_mem[code][exp_wr[code]] = req;
      exp_wr[code] = exp_wr[code] + 1;
    end
    req_valid_i = 1'b1;
    req_i       = req;
  endtask

  // Called on a falling edge with valid already high
  task automatic wait_accept(input int max_cycles);
    int  cycles;
    bit  done;
    cycles = 0;
    done   = 1'b0;
    while (!done) begin
      #(Quarter);
      if (req_ready_o) begin
        done = 1'b1;
      end else if (cycles >= max_cycles) begin
        stop_on_error($sformatf("Test %s: a write was never accepted", cur_test));
      end
      @(negedge clk_i);
      cycles = cycles + 1;
    end
    req_valid_i = 1'b0;
  endtask

  task automatic write_port(input int code, input bit to_far);
    drive_req(make_req(code), code, to_far);
    wait_accept(AcceptTimeout);
  endtask

  task automatic wait_responses(input int n);
    int cycles;
    cycles = 0;
    settle(1);
    while (resp_total - base_total < n) begin
      if (cycles >= RespTimeout) begin
        stop_on_error($sformatf("Test %s: only %0d of %0d responses arrived in time",
                                cur_test, resp_total - base_total, n));
      end
      settle(1);
      cycles = cycles + 1;
    end
    // Extra responses would show up here
    settle(20);
    check_value("response total", 64'(n), 64'(resp_total - base_total));
  endtask

  task automatic wait_isolated(input int port, input logic level);
    int cycles;
    cycles = 0;
    settle(1);
    while (isolated_o[port] !== level) begin
      if (cycles >= AcceptTimeout) begin
        stop_on_error($sformatf("Test %s: isolated_o of port %0d never changed", cur_test, port));
      end
      settle(1);
      cycles = cycles + 1;
    end
  endtask

  task automatic check_port_counts(input int port, input int okay, input int isol);
    check_value($sformatf("port %0d OKAY count", port), 64'(okay),
                64'(count_since(port, int'(bus_pkg::OKAY))));
    check_value($sformatf("port %0d ISOLATED count", port), 64'(isol),
                64'(count_since(port, int'(bus_pkg::ISOLATED))));
  endtask

  task automatic check_drained(input int port);
    check_value($sformatf("port %0d entries left unread", port), 64'(exp_wr[port]),
                64'(exp_rd[port]));
  endtask

  task automatic test_after_reset();
    cur_test = "after_reset";
    settle(1);
    check_value("resp_valid_o", 64'(0), 64'(resp_valid_o));
    check_value("isolated_o", 64'(0), 64'(isolated_o));
    check_value("async_wptr_o", 64'(0), 64'(async_wptr_o));
    check_value("req_ready_o", 64'(1), 64'(req_ready_o));
  endtask

  task automatic test_routing();
    cur_test = "routing";
    snap_counts();
    for (int p = 0; p < NumPorts; p++) begin
      for (int k = 0; k < 3; k++) begin
        write_port(p, 1'b1);
      end
    end
    wait_responses(3 * NumPorts);
    for (int p = 0; p < NumPorts; p++) begin
      check_port_counts(p, 3, 0);
      check_drained(p);
    end
    check_value("DECERR count", 64'(0), 64'(count_since(NumPorts, int'(bus_pkg::DECERR))));
  endtask

  task automatic test_decode_error();
    logic [NumPorts-1:0][LogDepth:0] wptr_before;
    cur_test = "decode_error";
    snap_counts();
    wptr_before = async_wptr_o;
    for (int code = NumPorts; code < NumCodes; code++) begin
      write_port(code, 1'b0);
    end
    wait_responses(NumCodes - NumPorts);
    check_value("DECERR count", 64'(NumCodes - NumPorts),
                64'(count_since(NumPorts, int'(bus_pkg::DECERR))));
    for (int p = 0; p < NumPorts; p++) begin
      check_port_counts(p, 0, 0);
    end
    check_value("write pointers", 64'(wptr_before), 64'(async_wptr_o));
  endtask

  task automatic test_back_pressure();
    cur_test = "back_pressure";
    snap_counts();
    pop_en[BpPort] = 1'b0;
    for (int k = 0; k < Depth; k++) begin
      write_port(BpPort, 1'b1);
    end
    // FIFO is full, this one has to wait
    drive_req(make_req(BpPort), BpPort, 1'b1);
    repeat (20) begin
      settle(1);
      check_value("req_ready_o while full", 64'(0), 64'(req_ready_o));
    end
    pop_en[BpPort] = 1'b1;
    @(negedge clk_i);
    wait_accept(AcceptTimeout);
    wait_responses(Depth + 1);
    check_port_counts(BpPort, Depth + 1, 0);
    check_drained(BpPort);
  endtask

  task automatic test_isolation();
    logic [LogDepth:0] wptr_before;
    cur_test = "isolation";
    snap_counts();
    pop_en[IsoPort] = 1'b0;
    write_port(IsoPort, 1'b1);
    write_port(IsoPort, 1'b1);
    @(negedge clk_i);
    isolate_i[IsoPort] = 1'b1;
    // Held request must wait for the drain, then gets answered locally
    drive_req(make_req(IsoPort), IsoPort, 1'b0);
    repeat (12) begin
      settle(1);
      check_value("isolated_o while draining", 64'(0), 64'(isolated_o[IsoPort]));
      check_value("req_ready_o while draining", 64'(0), 64'(req_ready_o));
    end
    pop_en[IsoPort] = 1'b1;
    @(negedge clk_i);
    wait_accept(AcceptTimeout);
    settle(1);
    check_value("isolated_o after drain", 64'(1), 64'(isolated_o[IsoPort]));
    wptr_before = async_wptr_o[IsoPort];
    repeat (3) write_port(IsoPort, 1'b0);
    wait_responses(6);
    check_port_counts(IsoPort, 2, 4);
    check_value("write pointer while isolated", 64'(wptr_before), 64'(async_wptr_o[IsoPort]));
    check_drained(IsoPort);
    @(negedge clk_i);
    isolate_i[IsoPort] = 1'b0;
    wait_isolated(IsoPort, 1'b0);
    snap_counts();
    write_port(IsoPort, 1'b1);
    write_port(IsoPort, 1'b1);
    wait_responses(2);
    check_port_counts(IsoPort, 2, 0);
    check_drained(IsoPort);
  endtask

  task automatic test_simultaneous();
    cur_test = "simultaneous";
    snap_counts();
    pop_en = '0;
    for (int k = 0; k < 3; k++) begin
      for (int p = 0; p < NumPorts; p++) begin
        write_port(p, 1'b1);
      end
    end
    // All far sides start reading together
    settle(1);
    pop_en = '1;
    wait_responses(3 * NumPorts);
    for (int p = 0; p < NumPorts; p++) begin
      check_port_counts(p, 3, 0);
      check_drained(p);
    end
  endtask

  initial begin
    void'($urandom(32'h218e));
    reset_i     = 1'b1;
    req_valid_i = 1'b0;
    req_i       = '0;
    isolate_i   = '0;
    pop_en      = '1;
    repeat (ResetCycles) @(negedge clk_i);
    reset_i = 1'b0;
    test_after_reset();
    test_routing();
    test_decode_error();
    test_back_pressure();
    test_isolation();
    test_simultaneous();
    $display("Simulation PASSED");
    $finish;
  end

endmodule

// ==== source/bus_pkg.sv ====
package bus_pkg;

  // Port index, wide enough for the whole select field
  typedef logic [wrap_cfg_pkg::PortSelWidth-1:0] port_id_t;

  // Host write request, also the FIFO entry
  typedef struct packed {
    logic [wrap_cfg_pkg::AddrWidth-1:0] addr;
    logic [wrap_cfg_pkg::DataWidth-1:0] data;
  } wr_req_t;

  // Completion status
  typedef enum logic [1:0] {
    OKAY     = 2'd0,
    ISOLATED = 2'd1,
    DECERR   = 2'd2
  } resp_status_e;

  // Response towards the host
  typedef struct packed {
    port_id_t     port;
    resp_status_e status;
  } wr_resp_t;

endpackage

// ==== source/cdc_fifo_src.sv ====
module cdc_fifo_src #(
  parameter int unsigned LogDepth   = wrap_cfg_pkg::DefaultLogDepth,
  parameter int unsigned SyncStages = wrap_cfg_pkg::DefaultSyncStages
) (
  input  logic                                  clk_i,
  input  logic                                  reset_i,
  // Local write side
  input  logic                                  push_i,
  input  bus_pkg::wr_req_t                      entry_i,
  output logic                                  full_o,
  output logic                                  empty_o,
  output logic                                  consumed_o,
  // Far side
  output bus_pkg::wr_req_t [2**LogDepth-1:0]    async_data_o,
  output logic [LogDepth:0]                     async_wptr_o,
  input  logic [LogDepth:0]                     async_rptr_i
);

  localparam int unsigned Depth = 2**LogDepth;

  // One extra bit tells full from empty
  typedef logic [LogDepth:0] ptr_t;

  function automatic ptr_t bin2gray(ptr_t bin);
    return bin ^ (bin >> 1);
  endfunction

  function automatic ptr_t gray2bin(ptr_t gray);
    ptr_t bin;
    bin[LogDepth] = gray[LogDepth];
    for (int i = int'(LogDepth) - 1; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];
    end
    return bin;
  endfunction

  bus_pkg::wr_req_t [Depth-1:0] data_q;
  ptr_t                         wptr_bin_q;
  ptr_t                         wptr_gray_q;
  ptr_t                         wptr_bin_next;
  ptr_t [SyncStages-1:0]        rptr_sync_q;
  ptr_t                         rptr_bin_q;
  ptr_t                         rptr_done_q;

  assign wptr_bin_next = wptr_bin_q + ptr_t'(1);

  // Entry array, read directly by the far side
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      data_q[wptr_bin_q[LogDepth-1:0]] <= entry_i;
    end
  end

  // Gray pointer is registered so the far side sees single-bit steps
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wptr_bin_q  <= '0;
      wptr_gray_q <= '0;
    end else if (push_i) begin
      wptr_bin_q  <= wptr_bin_next;
      wptr_gray_q <= bin2gray(wptr_bin_next);
    end
  end

  // Read pointer synchronizer, then a compare register in binary
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rptr_sync_q <= '0;
      rptr_bin_q  <= '0;
      rptr_done_q <= '0;
    end else begin
      rptr_sync_q[0] <= async_rptr_i;
      for (int i = 1; i < SyncStages; i++) begin
        rptr_sync_q[i] <= rptr_sync_q[i-1];
      end
      rptr_bin_q <= gray2bin(rptr_sync_q[SyncStages-1]);
      if (consumed_o) begin
        rptr_done_q <= rptr_done_q + ptr_t'(1);
      end
    end
  end

  // Walk behind the synchronized pointer one entry per cycle
  assign consumed_o = (rptr_done_q != rptr_bin_q);

  // Slots free up only after their consumed pulse
  assign empty_o = (wptr_bin_q == rptr_done_q);
  assign full_o  = (wptr_bin_q == {~rptr_done_q[LogDepth], rptr_done_q[LogDepth-1:0]});

  assign async_data_o = data_q;
  assign async_wptr_o = wptr_gray_q;

endmodule

// ==== source/ext_port_wrap.sv ====
module ext_port_wrap #(
  parameter int unsigned NumPorts   = wrap_cfg_pkg::DefaultNumPorts,
  parameter int unsigned LogDepth   = wrap_cfg_pkg::DefaultLogDepth,
  parameter int unsigned SyncStages = wrap_cfg_pkg::DefaultSyncStages
) (
  input  logic                                                clk_i,
  input  logic                                                reset_i,
  // Host write channel
  input  logic                                                req_valid_i,
  input  bus_pkg::wr_req_t                                    req_i,
  output logic                                                req_ready_o,
  // Host response stream
  output logic                                                resp_valid_o,
  output bus_pkg::wr_resp_t                                   resp_o,
  // Per-port isolation
  input  logic [NumPorts-1:0]                                 isolate_i,
  output logic [NumPorts-1:0]                                 isolated_o,
  // Per-port async FIFO write sides
  output bus_pkg::wr_req_t [NumPorts-1:0][2**LogDepth-1:0]    async_data_o,
  output logic [NumPorts-1:0][LogDepth:0]                     async_wptr_o,
  input  logic [NumPorts-1:0][LogDepth:0]                     async_rptr_i
);

  logic [NumPorts-1:0]                  port_valid;
  bus_pkg::wr_req_t                     port_req;
  logic [NumPorts-1:0]                  port_ready;
  logic [NumPorts-1:0]                  resp_pending;
  bus_pkg::resp_status_e [NumPorts-1:0] resp_status;
  logic [NumPorts-1:0]                  resp_grant;
  logic                                 decerr_pending;
  logic                                 decerr_grant;

  port_decoder #(
    .NumPorts ( NumPorts )
  ) i_port_decoder (
    .clk_i            ( clk_i          ),
    .reset_i          ( reset_i        ),
    .req_valid_i      ( req_valid_i    ),
    .req_i            ( req_i          ),
    .req_ready_o      ( req_ready_o    ),
    .port_valid_o     ( port_valid     ),
    .port_req_o       ( port_req       ),
    .port_ready_i     ( port_ready     ),
    .decerr_pending_o ( decerr_pending ),
    .decerr_grant_i   ( decerr_grant   )
  );

  for (genvar i = 0; i < NumPorts; i++) begin : gen_port
    port_channel #(
      .LogDepth   ( LogDepth   ),
      .SyncStages ( SyncStages )
    ) i_port_channel (
      .clk_i          ( clk_i           ),
      .reset_i        ( reset_i         ),
      .req_valid_i    ( port_valid[i]   ),
      .req_i          ( port_req        ),
      .req_ready_o    ( port_ready[i]   ),
      .isolate_i      ( isolate_i[i]    ),
      .isolated_o     ( isolated_o[i]   ),
      .resp_pending_o ( resp_pending[i] ),
      .resp_status_o  ( resp_status[i]  ),
      .resp_grant_i   ( resp_grant[i]   ),
      .async_data_o   ( async_data_o[i] ),
      .async_wptr_o   ( async_wptr_o[i] ),
      .async_rptr_i   ( async_rptr_i[i] )
    );
  end

  resp_collector #(
    .NumPorts ( NumPorts )
  ) i_resp_collector (
    .clk_i            ( clk_i          ),
    .reset_i          ( reset_i        ),
    .pending_i        ( resp_pending   ),
    .status_i         ( resp_status    ),
    .decerr_pending_i ( decerr_pending ),
    .grant_o          ( resp_grant     ),
    .decerr_grant_o   ( decerr_grant   ),
    .resp_valid_o     ( resp_valid_o   ),
    .resp_o           ( resp_o         )
  );

endmodule

// ==== source/port_channel.sv ====
module port_channel #(
  parameter int unsigned LogDepth   = wrap_cfg_pkg::DefaultLogDepth,
  parameter int unsigned SyncStages = wrap_cfg_pkg::DefaultSyncStages
) (
  input  logic                                  clk_i,
  input  logic                                  reset_i,
  // Request from the decoder
  input  logic                                  req_valid_i,
  input  bus_pkg::wr_req_t                      req_i,
  output logic                                  req_ready_o,
  // Isolation control
  input  logic                                  isolate_i,
  output logic                                  isolated_o,
  // Response offer towards the collector
  output logic                                  resp_pending_o,
  output bus_pkg::resp_status_e                 resp_status_o,
  input  logic                                  resp_grant_i,
  // Far side of the FIFO
  output bus_pkg::wr_req_t [2**LogDepth-1:0]    async_data_o,
  output logic [LogDepth:0]                     async_wptr_o,
  input  logic [LogDepth:0]                     async_rptr_i
);

  // Room for a full FIFO plus a backlog of owed responses
  localparam int unsigned CntWidth = LogDepth + 2;
  localparam logic [CntWidth-1:0] CntMax = '1;

  logic                push;
  logic                isol_accept;
  logic                full;
  logic                empty;
  logic                consumed;
  logic                okay_grant;
  logic                isol_grant;
  logic                drained;
  logic                isolated_q;
  logic [CntWidth-1:0] out_cnt_q;
  logic [CntWidth-1:0] okay_cnt_q;
  logic [CntWidth-1:0] isol_cnt_q;

  cdc_fifo_src #(
    .LogDepth   ( LogDepth   ),
    .SyncStages ( SyncStages )
  ) i_cdc_fifo_src (
    .clk_i        ( clk_i        ),
    .reset_i      ( reset_i      ),
    .push_i       ( push         ),
    .entry_i      ( req_i        ),
    .full_o       ( full         ),
    .empty_o      ( empty        ),
    .consumed_o   ( consumed     ),
    .async_data_o ( async_data_o ),
    .async_wptr_o ( async_wptr_o ),
    .async_rptr_i ( async_rptr_i )
  );

  // Stall while draining; once isolated every request is answered locally
  always_comb begin
    if (isolated_q) begin
      req_ready_o = (isol_cnt_q != CntMax);
    end else if (isolate_i) begin
      req_ready_o = 1'b0;
    end else begin
      req_ready_o = !full && (out_cnt_q != CntMax);
    end
  end

  assign push        = req_valid_i && req_ready_o && !isolated_q;
  assign isol_accept = req_valid_i && req_ready_o && isolated_q;

  // OKAY responses go first
  assign resp_pending_o = (okay_cnt_q != '0) || (isol_cnt_q != '0);
  assign resp_status_o  = (okay_cnt_q != '0) ? bus_pkg::OKAY : bus_pkg::ISOLATED;
  assign okay_grant     = resp_grant_i && (okay_cnt_q != '0);
  assign isol_grant     = resp_grant_i && (okay_cnt_q == '0);

  // Nothing left in the FIFO and no OKAY still owed
  assign drained = empty && (okay_cnt_q == '0);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      out_cnt_q  <= '0;
      okay_cnt_q <= '0;
      isol_cnt_q <= '0;
      isolated_q <= 1'b0;
    end else begin
      out_cnt_q  <= out_cnt_q + CntWidth'(push) - CntWidth'(okay_grant);
      okay_cnt_q <= okay_cnt_q + CntWidth'(consumed) - CntWidth'(okay_grant);
      isol_cnt_q <= isol_cnt_q + CntWidth'(isol_accept) - CntWidth'(isol_grant);
      isolated_q <= isolate_i && (isolated_q || drained);
    end
  end

  assign isolated_o = isolated_q;

endmodule

// ==== source/port_decoder.sv ====
module port_decoder #(
  parameter int unsigned NumPorts = wrap_cfg_pkg::DefaultNumPorts
) (
  input  logic                  clk_i,
  input  logic                  reset_i,
  // Host side
  input  logic                  req_valid_i,
  input  bus_pkg::wr_req_t      req_i,
  output logic                  req_ready_o,
  // Channel side
  output logic [NumPorts-1:0]   port_valid_o,
  output bus_pkg::wr_req_t      port_req_o,
  input  logic [NumPorts-1:0]   port_ready_i,
  // Owed decode-error responses
  output logic                  decerr_pending_o,
  input  logic                  decerr_grant_i
);

  localparam int unsigned CntWidth = 4;
  localparam logic [CntWidth-1:0] CntMax = '1;

  bus_pkg::port_id_t   sel;
  logic                in_range;
  logic                sel_ready;
  logic                decerr_accept;
  logic [CntWidth-1:0] decerr_cnt_q;

  assign sel      = req_i.addr[wrap_cfg_pkg::PortSelLsb +: wrap_cfg_pkg::PortSelWidth];
  assign in_range = (32'(sel) < NumPorts);

  // Payload goes to every channel, valid only to the addressed one
  assign port_req_o = req_i;

  always_comb begin
    sel_ready = 1'b0;
    for (int i = 0; i < NumPorts; i++) begin
      port_valid_o[i] = req_valid_i && (32'(sel) == i);
      if (32'(sel) == i) begin
        sel_ready = port_ready_i[i];
      end
    end
  end

  // Out-of-range codes are taken at once unless the owed counter is full
  assign decerr_accept = req_valid_i && !in_range && (decerr_cnt_q != CntMax);
  assign req_ready_o   = in_range ? sel_ready : (decerr_cnt_q != CntMax);

  assign decerr_pending_o = (decerr_cnt_q != '0);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      decerr_cnt_q <= '0;
    end else begin
      decerr_cnt_q <= decerr_cnt_q + CntWidth'(decerr_accept) - CntWidth'(decerr_grant_i);
    end
  end

endmodule

// ==== source/resp_collector.sv ====
module resp_collector #(
  parameter int unsigned NumPorts = wrap_cfg_pkg::DefaultNumPorts
) (
  input  logic                                  clk_i,
  input  logic                                  reset_i,
  // Per-port offers
  input  logic [NumPorts-1:0]                   pending_i,
  input  bus_pkg::resp_status_e [NumPorts-1:0]  status_i,
  input  logic                                  decerr_pending_i,
  output logic [NumPorts-1:0]                   grant_o,
  output logic                                  decerr_grant_o,
  // Merged response stream
  output logic                                  resp_valid_o,
  output bus_pkg::wr_resp_t                     resp_o
);

  // Decode errors take the slot after the last port
  localparam int unsigned NumSrc   = NumPorts + 1;
  localparam int unsigned IdxWidth = $clog2(NumSrc);

  logic [NumSrc-1:0]     req;
  logic                  gnt_valid;
  logic [IdxWidth-1:0]   gnt_idx;
  logic [IdxWidth-1:0]   prio_q;
  bus_pkg::resp_status_e gnt_status;
  logic                  resp_valid_q;
  bus_pkg::wr_resp_t     resp_q;

  assign req = {decerr_pending_i, pending_i};

  // First requester at or after the priority pointer
  always_comb begin
    int unsigned idx;
    gnt_valid = 1'b0;
    gnt_idx   = prio_q;
    for (int unsigned k = 0; k < NumSrc; k++) begin
      idx = 32'(prio_q) + k;
      if (idx >= NumSrc) begin
        idx = idx - NumSrc;
      end
      if (!gnt_valid && req[idx]) begin
        gnt_valid = 1'b1;
        gnt_idx   = IdxWidth'(idx);
      end
    end
  end

  always_comb begin
    gnt_status = bus_pkg::DECERR;
    for (int i = 0; i < NumPorts; i++) begin
      grant_o[i] = gnt_valid && (32'(gnt_idx) == i);
      if (32'(gnt_idx) == i) begin
        gnt_status = status_i[i];
      end
    end
  end

  assign decerr_grant_o = gnt_valid && (32'(gnt_idx) == NumPorts);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      prio_q       <= '0;
      resp_valid_q <= 1'b0;
    end else begin
      resp_valid_q <= gnt_valid;
      // Winner drops to lowest priority
      if (gnt_valid) begin
        prio_q <= (32'(gnt_idx) == NumPorts) ? '0 : gnt_idx + IdxWidth'(1);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (gnt_valid) begin
      resp_q.port   <= bus_pkg::port_id_t'(gnt_idx);
      resp_q.status <= gnt_status;
    end
  end

  assign resp_valid_o = resp_valid_q;
  assign resp_o       = resp_q;

endmodule

// ==== source/wrap_cfg_pkg.sv ====
package wrap_cfg_pkg;

  // Host bus widths
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;

  // Port select field inside the host address
  localparam int unsigned PortSelLsb   = 12;
  localparam int unsigned PortSelWidth = 3;

  // Default sizing handed down by the top level.
  // NumPorts must stay below 2**PortSelWidth so one code is left for decode errors
  localparam int unsigned DefaultNumPorts = 4;

  // FIFO depth is 2**LogDepth entries per port
  localparam int unsigned DefaultLogDepth = 2;

  // Read pointer synchronizer depth
  localparam int unsigned DefaultSyncStages = 2;

endpackage
